/* hw/ccu_pkg.sv */
`default_nettype none

package ccu_pkg;

  localparam int unsigned NUM_PORTS     = 3;
  localparam int unsigned ADDR_W        = 32;
  localparam int unsigned DATA_W        = 32; // One word per cache line
  localparam int unsigned LINE_OFFSET_W = 4;
  localparam int unsigned CM_IDX_W      = 6;
  localparam int unsigned MAX_WB        = 4;  // Conflict table depth
  localparam int unsigned PORT_ID_W     = 2;

  typedef enum logic [1:0] {
    OP_READ_SHARED,
    OP_READ_UNIQUE,  // Invalidates other copies
    OP_WRITE_BACK
  } ccu_op_e;

  typedef enum logic [2:0] {
    PS_IDLE,
    PS_SNOOP,
    PS_MEM_RD,
    PS_WB_SET,
    PS_MEM_WR,
    PS_DONE
  } port_state_e;

  typedef enum logic [2:0] {
    XS_IDLE,
    XS_CHECK,
    XS_ISSUE,
    XS_COLLECT,
    XS_REPLY
  } xbar_state_e;

  // First requester at or after ptr
  function automatic logic [PORT_ID_W-1:0] rr_pick(input logic [NUM_PORTS-1:0] req,
                                                   input logic [PORT_ID_W-1:0] ptr);
    int unsigned idx;
    rr_pick = ptr;
    for (int i = NUM_PORTS - 1; i >= 0; i--) begin
      idx = (int'(ptr) + i) % NUM_PORTS;
      if (req[idx]) rr_pick = idx[PORT_ID_W-1:0];
    end
  endfunction

  function automatic logic [PORT_ID_W-1:0] rr_next(input logic [PORT_ID_W-1:0] ptr);
    return (ptr == PORT_ID_W'(NUM_PORTS - 1)) ? '0 : ptr + 1'b1;
  endfunction

endpackage

`default_nettype wire

/* hw/ccu_port_path.sv */
`timescale 1ns/100ps
`default_nettype none

module ccu_port_path (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            req_i,
  input  ccu_pkg::ccu_op_e                op_i,
  input  logic [ccu_pkg::ADDR_W-1:0]      addr_i,
  input  logic [ccu_pkg::DATA_W-1:0]      wdata_i,
  output logic                            done_o,
  output logic [ccu_pkg::DATA_W-1:0]      rdata_o,
  output logic                            sn_req_o,
  output logic [ccu_pkg::ADDR_W-1:0]      sn_addr_o,
  output logic                            sn_inval_o,
  input  logic                            sn_done_i,
  input  logic                            sn_hit_i,
  input  logic [ccu_pkg::DATA_W-1:0]      sn_data_i,
  output logic                            mem_req_o,
  output logic                            mem_we_o,
  output logic [ccu_pkg::ADDR_W-1:0]      mem_addr_o,
  output logic [ccu_pkg::DATA_W-1:0]      mem_wdata_o,
  input  logic                            mem_done_i,
  input  logic [ccu_pkg::DATA_W-1:0]      mem_rdata_i,
  output logic                            cm_set_o,
  output logic                            cm_clr_o,
  output logic [ccu_pkg::CM_IDX_W-1:0]    cm_idx_o
);

  ccu_pkg::port_state_e state_q;
  logic [ccu_pkg::DATA_W-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ccu_pkg::PS_IDLE;
    end else begin
      case (state_q)
        ccu_pkg::PS_IDLE: begin
          if (req_i) begin
            state_q <= (op_i == ccu_pkg::OP_WRITE_BACK) ? ccu_pkg::PS_WB_SET
                                                        : ccu_pkg::PS_SNOOP;
          end
        end
        ccu_pkg::PS_SNOOP: begin
          if (sn_done_i) begin
            state_q <= sn_hit_i ? ccu_pkg::PS_DONE : ccu_pkg::PS_MEM_RD; // Miss goes to memory
          end
        end
        ccu_pkg::PS_MEM_RD: begin
          if (mem_done_i) state_q <= ccu_pkg::PS_DONE;
        end
        ccu_pkg::PS_WB_SET: state_q <= ccu_pkg::PS_MEM_WR;
        ccu_pkg::PS_MEM_WR: begin
          if (mem_done_i) state_q <= ccu_pkg::PS_DONE;
        end
        default: state_q <= ccu_pkg::PS_IDLE;
      endcase
    end
  end

  // Reply data from a snoop hit or from memory
  always_ff @(posedge clk_i) begin
    if (state_q == ccu_pkg::PS_SNOOP && sn_done_i && sn_hit_i) begin
      rdata_q <= sn_data_i;
    end else if (state_q == ccu_pkg::PS_MEM_RD && mem_done_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign done_o  = (state_q == ccu_pkg::PS_DONE);
  assign rdata_o = rdata_q;

  assign sn_req_o   = (state_q == ccu_pkg::PS_SNOOP);
  assign sn_addr_o  = addr_i;
  assign sn_inval_o = (op_i == ccu_pkg::OP_READ_UNIQUE);

  assign mem_req_o   = (state_q == ccu_pkg::PS_MEM_RD) || (state_q == ccu_pkg::PS_MEM_WR);
  assign mem_we_o    = (state_q == ccu_pkg::PS_MEM_WR);
  assign mem_addr_o  = addr_i;
  assign mem_wdata_o = wdata_i;

  // Write-back index lives in the table until memory is done
  assign cm_set_o = (state_q == ccu_pkg::PS_WB_SET);
  assign cm_clr_o = (state_q == ccu_pkg::PS_MEM_WR) && mem_done_i;
  assign cm_idx_o = addr_i[ccu_pkg::LINE_OFFSET_W +: ccu_pkg::CM_IDX_W];

endmodule

`default_nettype wire

/* hw/ccu_snoop_xbar.sv */
`timescale 1ns/100ps
`default_nettype none

module ccu_snoop_xbar (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0]                      inp_req_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0][ccu_pkg::ADDR_W-1:0] inp_addr_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0]                      inp_inval_i,
  output logic [ccu_pkg::NUM_PORTS-1:0]                      inp_done_o,
  output logic                                               inp_hit_o,
  output logic [ccu_pkg::DATA_W-1:0]                         inp_data_o,
  output logic [ccu_pkg::NUM_PORTS-1:0]                      oup_valid_o,
  output logic [ccu_pkg::ADDR_W-1:0]                         oup_addr_o,
  output logic                                               oup_inval_o,
  input  logic [ccu_pkg::NUM_PORTS-1:0]                      oup_resp_valid_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0]                      oup_hit_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0][ccu_pkg::DATA_W-1:0] oup_data_i,
  output logic                                               cm_req_o,
  output logic [ccu_pkg::CM_IDX_W-1:0]                       cm_idx_o,
  input  logic                                               cm_stall_i
);

  ccu_pkg::xbar_state_e state_q;
  logic [ccu_pkg::PORT_ID_W-1:0] sel_q;
  logic [ccu_pkg::PORT_ID_W-1:0] rr_q;
  logic [ccu_pkg::PORT_ID_W-1:0] hit_id_q;
  logic [ccu_pkg::NUM_PORTS-1:0] pend_q;
  logic [ccu_pkg::NUM_PORTS-1:0] others;
  logic                          hit_q;
  logic [ccu_pkg::DATA_W-1:0]    data_q;

  // Every port except the initiator
  always_comb begin
    others = '1;
    others[sel_q] = 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= ccu_pkg::XS_IDLE;
      sel_q    <= '0;
      rr_q     <= '0;
      hit_id_q <= '0;
      pend_q   <= '0;
      hit_q    <= 1'b0;
    end else begin
      case (state_q)
        ccu_pkg::XS_IDLE: begin
          if (|inp_req_i) begin
            sel_q   <= ccu_pkg::rr_pick(inp_req_i, rr_q);
            state_q <= ccu_pkg::XS_CHECK;
          end
        end
        ccu_pkg::XS_CHECK: begin
          if (!cm_stall_i) state_q <= ccu_pkg::XS_ISSUE; // Wait out pending write-back
        end
        ccu_pkg::XS_ISSUE: begin
          pend_q  <= others;
          hit_q   <= 1'b0;
          state_q <= ccu_pkg::XS_COLLECT;
        end
        ccu_pkg::XS_COLLECT: begin
          // Descending so the lowest hitting port wins within a cycle
          for (int p = ccu_pkg::NUM_PORTS - 1; p >= 0; p--) begin
            if (pend_q[p] && oup_resp_valid_i[p] && oup_hit_i[p] &&
                (!hit_q || p < hit_id_q)) begin
              hit_q    <= 1'b1;
              hit_id_q <= p[ccu_pkg::PORT_ID_W-1:0];
              data_q   <= oup_data_i[p];
            end
          end
          pend_q <= pend_q & ~oup_resp_valid_i;
          if ((pend_q & ~oup_resp_valid_i) == '0) state_q <= ccu_pkg::XS_REPLY;
        end
        ccu_pkg::XS_REPLY: begin
          rr_q    <= ccu_pkg::rr_next(sel_q);
          state_q <= ccu_pkg::XS_IDLE;
        end
        default: state_q <= ccu_pkg::XS_IDLE;
      endcase
    end
  end

  always_comb begin
    inp_done_o = '0;
    if (state_q == ccu_pkg::XS_REPLY) inp_done_o[sel_q] = 1'b1;
  end

  assign inp_hit_o  = hit_q;
  assign inp_data_o = data_q;

  assign oup_valid_o = (state_q == ccu_pkg::XS_ISSUE) ? others : '0;
  assign oup_addr_o  = inp_addr_i[sel_q];
  assign oup_inval_o = inp_inval_i[sel_q];

  assign cm_req_o = (state_q == ccu_pkg::XS_CHECK);
  assign cm_idx_o = oup_addr_o[ccu_pkg::LINE_OFFSET_W +: ccu_pkg::CM_IDX_W];

endmodule

`default_nettype wire

/* hw/ccu_mem_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module ccu_mem_arbiter (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0]                      req_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0]                      we_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0][ccu_pkg::ADDR_W-1:0] addr_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0][ccu_pkg::DATA_W-1:0] wdata_i,
  output logic [ccu_pkg::NUM_PORTS-1:0]                      done_o,
  output logic [ccu_pkg::DATA_W-1:0]                         rdata_o,
  output logic                                               mem_req_o,
  output logic                                               mem_we_o,
  output logic [ccu_pkg::ADDR_W-1:0]                         mem_addr_o,
  output logic [ccu_pkg::DATA_W-1:0]                         mem_wdata_o,
  input  logic                                               mem_done_i,
  input  logic [ccu_pkg::DATA_W-1:0]                         mem_rdata_i
);

  logic                          busy_q;
  logic [ccu_pkg::PORT_ID_W-1:0] owner_q;
  logic [ccu_pkg::PORT_ID_W-1:0] rr_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      owner_q <= '0;
      rr_q    <= '0;
    end else if (!busy_q) begin
      if (|req_i) begin
        busy_q  <= 1'b1;
        owner_q <= ccu_pkg::rr_pick(req_i, rr_q);
      end
    end else if (mem_done_i) begin
      busy_q <= 1'b0;
      rr_q   <= ccu_pkg::rr_next(owner_q); // Owner goes to the back
    end
  end

  assign mem_req_o   = busy_q;
  assign mem_we_o    = we_i[owner_q];
  assign mem_addr_o  = addr_i[owner_q];
  assign mem_wdata_o = wdata_i[owner_q];

  always_comb begin
    done_o = '0;
    if (busy_q && mem_done_i) done_o[owner_q] = 1'b1;
  end

  assign rdata_o = mem_rdata_i;

endmodule

`default_nettype wire

/* hw/ccu_conflict_manager.sv */
`timescale 1ns/100ps
`default_nettype none

module ccu_conflict_manager (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0]                        set_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0]                        clr_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0][ccu_pkg::CM_IDX_W-1:0] idx_i,
  input  logic                                                 snoop_req_i,
  input  logic [ccu_pkg::CM_IDX_W-1:0]                         snoop_idx_i,
  output logic                                                 snoop_stall_o
);

  logic [ccu_pkg::MAX_WB-1:0]                        valid_q;
  logic [ccu_pkg::MAX_WB-1:0]                        valid_d;
  logic [ccu_pkg::MAX_WB-1:0][ccu_pkg::CM_IDX_W-1:0] idx_q;
  logic [ccu_pkg::MAX_WB-1:0][ccu_pkg::CM_IDX_W-1:0] idx_d;

  always_comb begin : table_next
    logic taken;
    valid_d = valid_q;
    idx_d   = idx_q;
    for (int p = 0; p < ccu_pkg::NUM_PORTS; p++) begin
      taken = 1'b0;
      for (int e = 0; e < ccu_pkg::MAX_WB; e++) begin
        if (!taken && clr_i[p] && valid_d[e] && idx_d[e] == idx_i[p]) begin
          valid_d[e] = 1'b0; // Free one matching entry only
          taken = 1'b1;
        end else if (!taken && set_i[p] && !valid_d[e]) begin
          valid_d[e] = 1'b1;
          idx_d[e]   = idx_i[p];
          taken = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    idx_q <= idx_d;
  end

  // Hold the snoop while its line still has a write-back in flight
  always_comb begin
    snoop_stall_o = 1'b0;
    for (int e = 0; e < ccu_pkg::MAX_WB; e++) begin
      if (snoop_req_i && valid_q[e] && idx_q[e] == snoop_idx_i) snoop_stall_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/ccu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ccu_top (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0]                      port_req_i,
  input  ccu_pkg::ccu_op_e [ccu_pkg::NUM_PORTS-1:0]          port_op_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0][ccu_pkg::ADDR_W-1:0] port_addr_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0][ccu_pkg::DATA_W-1:0] port_wdata_i,
  output logic [ccu_pkg::NUM_PORTS-1:0]                      port_done_o,
  output logic [ccu_pkg::NUM_PORTS-1:0][ccu_pkg::DATA_W-1:0] port_rdata_o,
  output logic [ccu_pkg::NUM_PORTS-1:0]                      snoop_valid_o,
  output logic [ccu_pkg::ADDR_W-1:0]                         snoop_addr_o,
  output logic                                               snoop_inval_o,
  input  logic [ccu_pkg::NUM_PORTS-1:0]                      snoop_resp_valid_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0]                      snoop_hit_i,
  input  logic [ccu_pkg::NUM_PORTS-1:0][ccu_pkg::DATA_W-1:0] snoop_data_i,
  output logic                                               mem_req_o,
  output logic                                               mem_we_o,
  output logic [ccu_pkg::ADDR_W-1:0]                         mem_addr_o,
  output logic [ccu_pkg::DATA_W-1:0]                         mem_wdata_o,
  input  logic                                               mem_done_i,
  input  logic [ccu_pkg::DATA_W-1:0]                         mem_rdata_i
);

  // Port paths to snoop crossbar
  logic [ccu_pkg::NUM_PORTS-1:0]                      sn_req;
  logic [ccu_pkg::NUM_PORTS-1:0][ccu_pkg::ADDR_W-1:0] sn_addr;
  logic [ccu_pkg::NUM_PORTS-1:0]                      sn_inval;
  logic [ccu_pkg::NUM_PORTS-1:0]                      sn_done;
  logic                                               sn_hit;
  logic [ccu_pkg::DATA_W-1:0]                         sn_data;

  // Port paths to memory arbiter
  logic [ccu_pkg::NUM_PORTS-1:0]                      pm_req;
  logic [ccu_pkg::NUM_PORTS-1:0]                      pm_we;
  logic [ccu_pkg::NUM_PORTS-1:0][ccu_pkg::ADDR_W-1:0] pm_addr;
  logic [ccu_pkg::NUM_PORTS-1:0][ccu_pkg::DATA_W-1:0] pm_wdata;
  logic [ccu_pkg::NUM_PORTS-1:0]                      pm_done;
  logic [ccu_pkg::DATA_W-1:0]                         pm_rdata;

  // Conflict management
  logic [ccu_pkg::NUM_PORTS-1:0]                        cm_set;
  logic [ccu_pkg::NUM_PORTS-1:0]                        cm_clr;
  logic [ccu_pkg::NUM_PORTS-1:0][ccu_pkg::CM_IDX_W-1:0] cm_idx;
  logic                                                 cm_snoop_req;
  logic [ccu_pkg::CM_IDX_W-1:0]                         cm_snoop_idx;
  logic                                                 cm_stall;

  for (genvar p = 0; p < ccu_pkg::NUM_PORTS; p++) begin : g_port
    ccu_port_path i_port_path (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_i       (port_req_i[p]),
      .op_i        (port_op_i[p]),
      .addr_i      (port_addr_i[p]),
      .wdata_i     (port_wdata_i[p]),
      .done_o      (port_done_o[p]),
      .rdata_o     (port_rdata_o[p]),
      .sn_req_o    (sn_req[p]),
      .sn_addr_o   (sn_addr[p]),
      .sn_inval_o  (sn_inval[p]),
      .sn_done_i   (sn_done[p]),
      .sn_hit_i    (sn_hit),
      .sn_data_i   (sn_data),
      .mem_req_o   (pm_req[p]),
      .mem_we_o    (pm_we[p]),
      .mem_addr_o  (pm_addr[p]),
      .mem_wdata_o (pm_wdata[p]),
      .mem_done_i  (pm_done[p]),
      .mem_rdata_i (pm_rdata),
      .cm_set_o    (cm_set[p]),
      .cm_clr_o    (cm_clr[p]),
      .cm_idx_o    (cm_idx[p])
    );
  end

  ccu_snoop_xbar i_snoop_xbar (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .inp_req_i        (sn_req),
    .inp_addr_i       (sn_addr),
    .inp_inval_i      (sn_inval),
    .inp_done_o       (sn_done),
    .inp_hit_o        (sn_hit),
    .inp_data_o       (sn_data),
    .oup_valid_o      (snoop_valid_o),
    .oup_addr_o       (snoop_addr_o),
    .oup_inval_o      (snoop_inval_o),
    .oup_resp_valid_i (snoop_resp_valid_i),
    .oup_hit_i        (snoop_hit_i),
    .oup_data_i       (snoop_data_i),
    .cm_req_o         (cm_snoop_req),
    .cm_idx_o         (cm_snoop_idx),
    .cm_stall_i       (cm_stall)
  );

  ccu_mem_arbiter i_mem_arbiter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (pm_req),
    .we_i        (pm_we),
    .addr_i      (pm_addr),
    .wdata_i     (pm_wdata),
    .done_o      (pm_done),
    .rdata_o     (pm_rdata),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_done_i  (mem_done_i),
    .mem_rdata_i (mem_rdata_i)
  );

  ccu_conflict_manager i_conflict_manager (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .set_i         (cm_set),
    .clr_i         (cm_clr),
    .idx_i         (cm_idx),
    .snoop_req_i   (cm_snoop_req),
    .snoop_idx_i   (cm_snoop_idx),
    .snoop_stall_o (cm_stall)
  );

endmodule

`default_nettype wire

/* verif/ccu_tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module ccu_tb_clock #(
  parameter real PERIOD_NS = 100.0
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* verif/ccu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ccu_tb;

  localparam int unsigned N     = ccu_pkg::NUM_PORTS;
  localparam int unsigned TXNS  = 200;
  localparam int unsigned LINES = 8;
  localparam int unsigned LIMIT = TXNS * N * 40;

  logic                                       clk;
  logic                                       rst;
  logic [N-1:0]                               port_req;
  ccu_pkg::ccu_op_e [N-1:0]                   port_op;
  logic [N-1:0][ccu_pkg::ADDR_W-1:0]          port_addr;
  logic [N-1:0][ccu_pkg::DATA_W-1:0]          port_wdata;
  logic [N-1:0]                               port_done;
  logic [N-1:0][ccu_pkg::DATA_W-1:0]          port_rdata;
  logic [N-1:0]                               snoop_valid;
  logic [ccu_pkg::ADDR_W-1:0]                 snoop_addr;
  logic                                       snoop_inval;
  logic [N-1:0]                               snoop_resp_valid;
  logic [N-1:0]                               snoop_hit;
  logic [N-1:0][ccu_pkg::DATA_W-1:0]          snoop_data;
  logic                                       mem_req;
  logic                                       mem_we;
  logic [ccu_pkg::ADDR_W-1:0]                 mem_addr;
  logic [ccu_pkg::DATA_W-1:0]                 mem_wdata;
  logic                                       mem_done;
  logic [ccu_pkg::DATA_W-1:0]                 mem_rdata;

  // Model state, one word per line
  bit                         held_v [N][LINES];
  logic [ccu_pkg::DATA_W-1:0] held_d [N][LINES];
  logic [ccu_pkg::DATA_W-1:0] mem_d [LINES];
  logic [ccu_pkg::DATA_W-1:0] exp_mem [LINES]; // Line contents after completed write-backs
  int unsigned                sn_cnt [N];
  bit                         exp_hit [N];
  logic [ccu_pkg::DATA_W-1:0] exp_data [N];
  int unsigned                mem_cnt;
  int unsigned                req_cnt [N];
  int unsigned                done_cnt [N];
  int unsigned                wb_done;
  int unsigned                mem_writes;
  int unsigned                errors;
  int unsigned                checks;
  int unsigned                cycles;

  ccu_tb_clock #(.PERIOD_NS(100.0)) clock_inst (.clk_o(clk));

  ccu_top ccu_top_inst (
    .clk_i              (clk),
    .rst_i              (rst),
    .port_req_i         (port_req),
    .port_op_i          (port_op),
    .port_addr_i        (port_addr),
    .port_wdata_i       (port_wdata),
    .port_done_o        (port_done),
    .port_rdata_o       (port_rdata),
    .snoop_valid_o      (snoop_valid),
    .snoop_addr_o       (snoop_addr),
    .snoop_inval_o      (snoop_inval),
    .snoop_resp_valid_i (snoop_resp_valid),
    .snoop_hit_i        (snoop_hit),
    .snoop_data_i       (snoop_data),
    .mem_req_o          (mem_req),
    .mem_we_o           (mem_we),
    .mem_addr_o         (mem_addr),
    .mem_wdata_o        (mem_wdata),
    .mem_done_i         (mem_done),
    .mem_rdata_i        (mem_rdata)
  );

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_rule(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("Rule broken at cycle %0d: %s", cycles, what);
    end
  endtask

  // One cache's request stream over the shared lines
  task automatic drive_port(input int p);
    int unsigned line;
    repeat (TXNS) begin
      repeat (1 + $urandom % 4) @(posedge clk);
      line = $urandom % LINES;
      port_op[p]    <= ccu_pkg::ccu_op_e'($urandom % 3);
      port_addr[p]  <= line * 16;
      port_wdata[p] <= $urandom;
      port_req[p]   <= 1'b1;
      do @(posedge clk); while (!port_done[p]);
      port_req[p] <= 1'b0;
      req_cnt[p]++;
    end
  endtask

  // Cache models and reply checks
  always @(posedge clk) begin : cache_model
    int unsigned line;
    int unsigned init;
    bit          found;
    if (rst) begin
      snoop_resp_valid <= '0;
      for (int p = 0; p < N; p++) sn_cnt[p] = 0;
    end else begin
      snoop_resp_valid <= '0;
      if (|snoop_valid) begin
        line = snoop_addr[6:4];
        init = 0;
        for (int p = 0; p < N; p++) if (!snoop_valid[p]) init = p;
        check_rule($countones(snoop_valid) == N - 1, "snoop not sent to all other ports");
        check_rule(port_req[init] && port_op[init] != ccu_pkg::OP_WRITE_BACK,
                   "snoop initiator has no read open");
        check_value("snoop_addr_o", snoop_addr, port_addr[init]);
        check_value("snoop_inval_o", snoop_inval, port_op[init] == ccu_pkg::OP_READ_UNIQUE);
        check_rule(!(mem_req && mem_we && mem_addr[9:4] == snoop_addr[9:4]),
                   "snoop issued while a write-back to its line is open");
        found = 1'b0;
        for (int p = 0; p < N; p++) begin
          if (p != init && held_v[p][line] && !found) begin
            found          = 1'b1;
            exp_data[init] = held_d[p][line]; // Lowest holder wins
          end
        end
        exp_hit[init] = found;
      end
      for (int p = 0; p < N; p++) begin
        if (snoop_valid[p]) begin
          snoop_hit[p]  <= held_v[p][snoop_addr[6:4]];
          snoop_data[p] <= held_d[p][snoop_addr[6:4]];
          if (snoop_inval) held_v[p][snoop_addr[6:4]] = 1'b0;
          sn_cnt[p] = 1 + $urandom % 4;
        end else if (sn_cnt[p] != 0) begin
          sn_cnt[p]--;
          if (sn_cnt[p] == 0) snoop_resp_valid[p] <= 1'b1;
        end
      end
      for (int p = 0; p < N; p++) begin
        if (port_done[p]) begin
          line = port_addr[p][6:4];
          done_cnt[p]++;
          check_rule(port_req[p], "port_done_o without an open request");
          if (port_op[p] == ccu_pkg::OP_WRITE_BACK) begin
            held_v[p][line] = 1'b0; // Evicted
            exp_mem[line]   = port_wdata[p];
            wb_done++;
          end else begin
            if (exp_hit[p]) check_value("port_rdata_o hit", port_rdata[p], exp_data[p]);
            else check_value("port_rdata_o miss", port_rdata[p], exp_mem[line]);
            held_v[p][line] = 1'b1;
            held_d[p][line] = port_rdata[p];
          end
        end
      end
    end
  end

  always @(posedge clk) begin : memory_model
    int unsigned line;
    line = mem_addr[6:4];
    if (rst) begin
      mem_done <= 1'b0;
      mem_cnt = 0;
    end else if (mem_done) begin
      mem_done <= 1'b0; // Arbiter drops the request next cycle
    end else if (mem_cnt != 0) begin
      mem_cnt--;
      if (mem_cnt == 0) begin
        mem_done <= 1'b1;
        if (mem_we) begin
          mem_d[line] = mem_wdata;
          mem_writes++;
        end else begin
          mem_rdata <= mem_d[line];
        end
      end
    end else if (mem_req) begin
      mem_cnt = 1 + $urandom % 6;
    end
  end

  always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles with requests still open", cycles);
      $display("errors: %0d of %0d checks", errors, checks);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h0dc959c8));
    rst              = 1'b1;
    port_req         = '0;
    port_addr        = '0;
    port_wdata       = '0;
    snoop_resp_valid = '0;
    snoop_hit        = '0;
    snoop_data       = '0;
    mem_done         = 1'b0;
    mem_rdata        = '0;
    for (int p = 0; p < N; p++) port_op[p] = ccu_pkg::OP_READ_SHARED;
    for (int k = 0; k < LINES; k++) begin
      mem_d[k]   = k * 16; // Unwritten lines read as address
      exp_mem[k] = k * 16;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    fork
      drive_port(0);
      drive_port(1);
      drive_port(2);
    join
    repeat (10) @(posedge clk);
    for (int p = 0; p < N; p++) check_value("done count", done_cnt[p], req_cnt[p]);
    check_value("memory writes", mem_writes, wb_done);
    $display("errors: %0d of %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
hw/ccu_pkg.sv
hw/ccu_port_path.sv
hw/ccu_snoop_xbar.sv
hw/ccu_mem_arbiter.sv
hw/ccu_conflict_manager.sv
hw/ccu_top.sv
verif/ccu_tb_clock.sv
verif/ccu_tb.sv

/* Bender.yml */
package:
  name: ccu

sources:
  - files:
      - hw/ccu_pkg.sv
      - hw/ccu_port_path.sv
      - hw/ccu_snoop_xbar.sv
      - hw/ccu_mem_arbiter.sv
      - hw/ccu_conflict_manager.sv
      - hw/ccu_top.sv
  - target: test
    files:
      - verif/ccu_tb_clock.sv
      - verif/ccu_tb.sv
